/* dv/calcTb.sv */
`timescale 1ns/100ps

module calcTb;

    localparam int ScanDivBits   = 2;
    localparam int SlotCycles    = 1 << ScanDivBits;
    localparam int ScanCycles    = 8 * SlotCycles;
    localparam int SettleCycles  = 4;
    localparam int FileVectors   = 15;
    localparam int FieldsPerLine = 7;
    localparam int RandomVectors = 40;
    localparam int NumVectors    = FileVectors + RandomVectors;
    localparam int TimeoutCycles = NumVectors * 40 + 100;

    // One stimulus with the result it should produce
    typedef struct packed {
        calcPkg::aluOp     op;
        calcPkg::signMag   operandA;
        calcPkg::signMag   operandB;
        calcPkg::aluResult expected;
    } testVector;

    logic               clk;
    logic               reset;
    calcPkg::aluOp      op;
    calcPkg::signMag    operandA;
    calcPkg::signMag    operandB;
    calcPkg::segPattern sseg;
    logic [7:0]         an;
    logic               dp;

    logic [7:0]  fileWords [0:FileVectors*FieldsPerLine-1];
    testVector   vectors [$];
    logic [31:0] rngState;
    int          cycleCount = 0;
    int          scanTick;

    calcDisplayTop #(
        .ScanDivBits (ScanDivBits)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .sseg     (sseg),
        .an       (an),
        .dp       (dp)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles)
        begin
            failRun($sformatf("Timeout after %0d cycles, the tests did not finish", cycleCount));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Plain signed integer arithmetic with zero kept positive
    function automatic calcPkg::aluResult modelResult(input calcPkg::aluOp opIn,
                                                      input calcPkg::signMag a,
                                                      input calcPkg::signMag b);
        int                valueA;
        int                valueB;
        int                total;
        calcPkg::aluResult r;
        valueA = a.sign ? -int'(a.magnitude) : int'(a.magnitude);
        valueB = b.sign ? -int'(b.magnitude) : int'(b.magnitude);
        case (opIn)
            calcPkg::opAdd: total = valueA + valueB;
            calcPkg::opSub: total = valueA - valueB;
            calcPkg::opMul: total = valueA * valueB;
            default:        total = 0;
        endcase
        r.sign      = (total < 0);
        r.magnitude = 8'((total < 0) ? -total : total);
        return r;
    endfunction

    function automatic calcPkg::segPattern signSegments(input logic negative);
        return negative ? calcPkg::segMinus : calcPkg::segPlus;
    endfunction

    function automatic calcPkg::segPattern expectedSegments(input int pos, input testVector v);
        int mag;
        mag = v.expected.magnitude;
        case (pos)
            0: return calcPkg::segDigit[v.operandA.magnitude % 10];
            1: return signSegments(v.operandA.sign);
            2: return calcPkg::segDigit[v.operandB.magnitude % 10];
            3: return signSegments(v.operandB.sign);
            4: return calcPkg::segDigit[mag % 10];
            5: return calcPkg::segDigit[(mag / 10) % 10];
            6: return (mag == 0) ? calcPkg::segBlank : signSegments(v.expected.sign);
            default: return calcPkg::segOp[v.op];
        endcase
    endfunction

    // Sign slot stays dark for a zero result
    function automatic logic [7:0] expectedAnodes(input int pos, input testVector v);
        logic [7:0] pattern;
        pattern = 8'hFF;
        if (!((pos == 6) && (v.expected.magnitude == 8'd0)))
        begin
            pattern[pos] = 1'b0;
        end
        return pattern;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkSegments(input string name, input calcPkg::segPattern expected,
                                 input calcPkg::segPattern actual);
        if (actual !== expected)
        begin
            failRun($sformatf("error %s: expected sseg %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkAnodes(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected)
        begin
            failRun($sformatf("error %s: expected an %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkDecimalPoint(input string name, input logic expected,
                                     input logic actual);
        if (actual !== expected)
        begin
            failRun($sformatf("error %s: expected dp %b actual %b", name, expected, actual));
        end
    endtask

    // Position follows from the cycles since the first lit slot
    task automatic checkCycle(input testVector v, input string name);
        int    pos;
        string where;
        pos   = (scanTick / SlotCycles) % 8;
        where = $sformatf("%s pos %0d", name, pos);
        checkAnodes(where, expectedAnodes(pos, v), an);
        checkSegments(where, expectedSegments(pos, v), sseg);
        checkDecimalPoint(where, 1'b1, dp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic loadVectors();
        testVector v;
        int        base;
        $readmemh("dv/calcTestdata.txt", fileWords);
        for (int i = 0; i < FileVectors; i++)
        begin
            base = i * FieldsPerLine;
            for (int f = 0; f < FieldsPerLine; f++)
            begin
                if ($isunknown(fileWords[base + f]))
                begin
                    failRun("The test data file is missing or has too few entries");
                end
            end
            v.op                 = calcPkg::aluOp'(fileWords[base][1:0]);
            v.operandA.sign      = fileWords[base + 1][0];
            v.operandA.magnitude = fileWords[base + 2][3:0];
            v.operandB.sign      = fileWords[base + 3][0];
            v.operandB.magnitude = fileWords[base + 4][3:0];
            v.expected.sign      = fileWords[base + 5][0];
            v.expected.magnitude = fileWords[base + 6];
            vectors.push_back(v);
        end
        for (int i = 0; i < RandomVectors; i++)
        begin
            rngState             = nextRandom(rngState);
            v.op                 = calcPkg::aluOp'(rngState[1:0]);
            v.operandA.sign      = rngState[4];
            v.operandA.magnitude = rngState[11:8];
            v.operandB.sign      = rngState[16];
            v.operandB.magnitude = rngState[23:20];
            v.expected           = modelResult(v.op, v.operandA, v.operandB);
            vectors.push_back(v);
        end
    endtask

    task automatic applyVector(input testVector v, input string name);
        @(negedge clk);
        scanTick++;
        op       = v.op;
        operandA = v.operandA;
        operandB = v.operandB;
        repeat (SettleCycles)
        begin
            @(negedge clk);
            scanTick++;
        end
        repeat (ScanCycles)
        begin
            @(negedge clk);
            scanTick++;
            checkCycle(v, name);
        end
    endtask

    initial
    begin
        testVector idle;
        int        waited;
        reset     = 1'b1;
        op        = calcPkg::opClear;
        operandA  = '0;
        operandB  = '0;
        scanTick  = 0;
        waited    = 0;
        rngState  = 32'd76;
        loadVectors();

        // Everything dark while reset is held
        repeat (8)
        begin
            @(negedge clk);
            checkAnodes("reset", 8'hFF, an);
            checkSegments("reset", calcPkg::segBlank, sseg);
        end
        reset = 1'b0;

        // The scan must open with position 0
        @(negedge clk);
        while ((an == 8'hFF) && (waited < ScanCycles))
        begin
            @(negedge clk);
            waited++;
        end
        checkAnodes("first lit", 8'hFE, an);

        idle.op       = calcPkg::opClear;
        idle.operandA = '0;
        idle.operandB = '0;
        idle.expected = modelResult(idle.op, idle.operandA, idle.operandB);
        scanTick      = 0;
        checkCycle(idle, "after reset");
        repeat (ScanCycles - 1)
        begin
            @(negedge clk);
            scanTick++;
            checkCycle(idle, "after reset");
        end

        foreach (vectors[i])
        begin
            applyVector(vectors[i], $sformatf("vector %0d op %0d", i, vectors[i].op));
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* dv/calcTestdata.txt */
// Hex fields per line: op signA magA signB magB expectedSign expectedMagnitude
// op 0 clear, 1 add, 2 subtract (A minus B), 3 multiply; sign 1 means negative
1 0 5 0 3 0 08
1 0 9 1 4 0 05
1 1 7 0 2 1 05
1 1 8 1 9 1 11
1 0 6 1 6 0 00
2 0 3 0 a 1 07
2 1 5 1 c 0 07
2 0 f 1 f 0 1e
2 1 9 0 9 1 12
2 1 4 1 4 0 00
3 0 f 0 f 0 e1
3 1 f 0 f 1 e1
3 1 7 1 0 0 00
3 1 c 0 b 1 84
0 1 d 0 6 0 00

/* rtl/bcdConverter.sv */
`timescale 1ns/100ps

module bcdConverter (
    input  logic              clk,
    input  logic              reset,
    input  calcPkg::aluResult result,
    output calcPkg::bcdResult digits
);

    // Hundreds [19:16], tens [15:12], ones [11:8], binary [7:0]
    logic [19:0] shiftReg;

    //////////////////////////////////////////////////////////////////////
    // Double dabble, one pass per magnitude bit
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        shiftReg = {12'd0, result.magnitude};
        for (int i = 0; i < 8; i++)
        begin
            if (shiftReg[11:8] >= 4'd5)
            begin
                shiftReg[11:8] = shiftReg[11:8] + 4'd3;
            end
            if (shiftReg[15:12] >= 4'd5)
            begin
                shiftReg[15:12] = shiftReg[15:12] + 4'd3;
            end
            if (shiftReg[19:16] >= 4'd5)
            begin
                shiftReg[19:16] = shiftReg[19:16] + 4'd3;
            end
            shiftReg = shiftReg << 1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            digits <= '0;
        end
        else
        begin
            digits.sign     <= result.sign;
            digits.hundreds <= shiftReg[19:16];
            digits.tens     <= shiftReg[15:12];
            digits.ones     <= shiftReg[11:8];
        end
    end

    // Correction steps must leave only decimal digits
    digitRange: assert property (
        @(posedge clk) disable iff (reset)
        (digits.hundreds <= 4'd9) && (digits.tens <= 4'd9) && (digits.ones <= 4'd9)
    );

endmodule

/* rtl/calcDisplayTop.sv */
`timescale 1ns/100ps

module calcDisplayTop #(
    parameter int ScanDivBits = 18
) (
    input  logic               clk,
    input  logic               reset,
    input  calcPkg::aluOp      op,
    input  calcPkg::signMag    operandA,
    input  calcPkg::signMag    operandB,
    output calcPkg::segPattern sseg,
    output logic [7:0]         an,
    output logic               dp
);

    calcPkg::aluResult aluOut;
    calcPkg::bcdResult bcdOut;
    calcPkg::glyphSel  glyph;

    // No decimal point on this display
    assign dp = 1'b1;

    signedMagAlu uAlu (
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .result   (aluOut)
    );

    bcdConverter uBcd (
        .clk    (clk),
        .reset  (reset),
        .result (aluOut),
        .digits (bcdOut)
    );

    displayScanner #(
        .ScanDivBits (ScanDivBits)
    ) uScanner (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .digits   (bcdOut),
        .glyph    (glyph),
        .an       (an)
    );

    segmentEncoder uEncoder (
        .clk   (clk),
        .reset (reset),
        .glyph (glyph),
        .sseg  (sseg)
    );

    // Product sign follows the operand signs unless the product is zero
    mulSign: assert property (
        @(posedge clk) disable iff (reset)
        ((op == calcPkg::opMul) && (aluOut.magnitude != 8'd0))
            |-> (aluOut.sign == (operandA.sign ^ operandB.sign))
    );

endmodule

/* rtl/calcPkg.sv */
package calcPkg;

    //////////////////////////////////////////////////////////////////////
    // Operand and result words
    //////////////////////////////////////////////////////////////////////

    // One switch operand, sign set means negative
    typedef struct packed {
        logic       sign;
        logic [3:0] magnitude;
    } signMag;

    typedef struct packed {
        logic       sign;
        logic [7:0] magnitude;
    } aluResult;

    // Decimal form of the result, hundreds never shown
    typedef struct packed {
        logic       sign;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcdResult;

    typedef enum logic [1:0] {
        opClear = 2'd0,
        opAdd   = 2'd1,
        opSub   = 2'd2,
        opMul   = 2'd3
    } aluOp;

    //////////////////////////////////////////////////////////////////////
    // Display glyphs
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        glyphDigit = 2'd0,
        glyphSign  = 2'd1,
        glyphOp    = 2'd2,
        glyphBlank = 2'd3
    } glyphKind;

    // Value holds a digit, a sign in bit 0 or an op code in bits 1:0
    typedef struct packed {
        glyphKind   kind;
        logic [3:0] value;
    } glyphSel;

    // Active low, bit order g f e d c b a
    typedef logic [6:0] segPattern;

    localparam segPattern segDigit [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b1000000, 7'b1111001,
        7'b0100100, 7'b0110000, 7'b0011001, 7'b0010010
    };

    localparam segPattern segPlus  = 7'b0101110;
    localparam segPattern segMinus = 7'b0100101;

    // Symbols for clear, add, subtract, multiply
    localparam segPattern segOp [4] = '{
        7'b1000000, 7'b0100100, 7'b0011001, 7'b1111000
    };

    localparam segPattern segBlank = 7'b1111111;

endpackage

/* rtl/displayScanner.sv */
`timescale 1ns/100ps

module displayScanner #(
    parameter int ScanDivBits = 18
) (
    input  logic              clk,
    input  logic              reset,
    input  calcPkg::aluOp     op,
    input  calcPkg::signMag   operandA,
    input  calcPkg::signMag   operandB,
    input  calcPkg::bcdResult digits,
    output calcPkg::glyphSel  glyph,
    output logic [7:0]        an
);

    localparam int CountBits = ScanDivBits + 3;

    logic [CountBits-1:0] scanCount;
    logic [2:0]           position;
    logic                 resultZero;

    calcPkg::glyphSel     glyphNext;
    logic [7:0]           anNext;

    // Extra anode stage, matches the encoder register
    logic [7:0]           anStage;

    assign position   = scanCount[CountBits-1 -: 3];
    assign resultZero = (digits.hundreds == 4'd0) && (digits.tens == 4'd0)
                        && (digits.ones == 4'd0);

    //////////////////////////////////////////////////////////////////////
    // Glyph for the current position
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        glyphNext.kind  = calcPkg::glyphDigit;
        glyphNext.value = 4'd0;
        case (position)
            3'd0: glyphNext.value = operandA.magnitude;
            3'd1:
            begin
                glyphNext.kind  = calcPkg::glyphSign;
                glyphNext.value = {3'b000, operandA.sign};
            end
            3'd2: glyphNext.value = operandB.magnitude;
            3'd3:
            begin
                glyphNext.kind  = calcPkg::glyphSign;
                glyphNext.value = {3'b000, operandB.sign};
            end
            3'd4: glyphNext.value = digits.ones;
            3'd5: glyphNext.value = digits.tens;
            3'd6:
            begin
                // Zero result leaves the sign slot dark
                glyphNext.kind  = resultZero ? calcPkg::glyphBlank : calcPkg::glyphSign;
                glyphNext.value = {3'b000, digits.sign};
            end
            default:
            begin
                glyphNext.kind  = calcPkg::glyphOp;
                glyphNext.value = {2'b00, op};
            end
        endcase
    end

    always_comb
    begin
        anNext           = 8'hFF;
        anNext[position] = 1'b0;
        if ((position == 3'd6) && resultZero)
        begin
            anNext[6] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            scanCount <= '0;
            glyph     <= '{kind: calcPkg::glyphBlank, value: 4'd0};
            anStage   <= 8'hFF;
            an        <= 8'hFF;
        end
        else
        begin
            scanCount <= scanCount + 1'b1;
            glyph     <= glyphNext;
            anStage   <= anNext;
            an        <= anStage;
        end
    end

    // Never two digits lit at once
    anodeOneHot: assert property (
        @(posedge clk) disable iff (reset) $countones(~an) <= 1
    );

endmodule

/* rtl/segmentEncoder.sv */
`timescale 1ns/100ps

module segmentEncoder (
    input  logic               clk,
    input  logic               reset,
    input  calcPkg::glyphSel   glyph,
    output calcPkg::segPattern sseg
);

    calcPkg::segPattern patternNext;

    //////////////////////////////////////////////////////////////////////
    // Glyph lookup
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (glyph.kind)
            calcPkg::glyphDigit:
            begin
                // Values above nine wrap onto 0 to 5
                patternNext = calcPkg::segDigit[glyph.value];
            end
            calcPkg::glyphSign:
            begin
                if (glyph.value[0])
                begin
                    patternNext = calcPkg::segMinus;
                end
                else
                begin
                    patternNext = calcPkg::segPlus;
                end
            end
            calcPkg::glyphOp:
            begin
                patternNext = calcPkg::segOp[glyph.value[1:0]];
            end
            default:
            begin
                patternNext = calcPkg::segBlank;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    // One cycle behind the glyph so the scanner delays an to match
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sseg <= calcPkg::segBlank;
        end
        else
        begin
            sseg <= patternNext;
        end
    end

endmodule

/* rtl/signedMagAlu.sv */
`timescale 1ns/100ps

module signedMagAlu (
    input  calcPkg::aluOp     op,
    input  calcPkg::signMag   operandA,
    input  calcPkg::signMag   operandB,
    output calcPkg::aluResult result
);

    // Sign of B as seen by the adder, flipped for subtract
    logic       signBEff;
    logic       aGreaterEq;

    // Magnitudes widened to the result width
    logic [7:0] magA;
    logic [7:0] magB;

    logic [7:0] sumMag;
    logic [7:0] diffMag;
    logic [7:0] prodMag;

    logic [7:0] addMag;
    logic       addSign;

    logic [7:0] rawMag;
    logic       rawSign;

    assign magA = {4'b0000, operandA.magnitude};
    assign magB = {4'b0000, operandB.magnitude};

    assign signBEff   = operandB.sign ^ (op == calcPkg::opSub);
    assign aGreaterEq = (operandA.magnitude >= operandB.magnitude);

    assign sumMag  = magA + magB;
    assign diffMag = aGreaterEq ? (magA - magB) : (magB - magA);

    // 15 x 15 = 225 still fits in eight bits
    assign prodMag = magA * magB;

    //////////////////////////////////////////////////////////////////////
    // Signed add path
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (operandA.sign == signBEff)
        begin
            // Same signs, magnitudes add
            addMag  = sumMag;
            addSign = operandA.sign;
        end
        else
        begin
            // Opposite signs, larger magnitude wins the sign
            addMag  = diffMag;
            addSign = aGreaterEq ? operandA.sign : signBEff;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (op)
            calcPkg::opClear:
            begin
                rawMag  = 8'd0;
                rawSign = 1'b0;
            end
            calcPkg::opAdd,
            calcPkg::opSub:
            begin
                rawMag  = addMag;
                rawSign = addSign;
            end
            calcPkg::opMul:
            begin
                rawMag  = prodMag;
                rawSign = operandA.sign ^ operandB.sign;
            end
            default:
            begin
                rawMag  = 8'd0;
                rawSign = 1'b0;
            end
        endcase
    end

    // Zero is always positive
    assign result.magnitude = rawMag;
    assign result.sign      = rawSign && (rawMag != 8'd0);

endmodule

/* src.f */
rtl/calcPkg.sv
rtl/signedMagAlu.sv
rtl/bcdConverter.sv
rtl/displayScanner.sv
rtl/segmentEncoder.sv
rtl/calcDisplayTop.sv
dv/calcTb.sv
